// ==== common/execPkg.sv ====
`default_nettype none

package execPkg;

    // data and instruction widths, fixed by RV64
    typedef logic [63:0] xlenT;
    typedef logic [31:0] instrT;
    typedef logic [5:0]  shamtT;

    // result select; the low three bits follow funct3 of the base ops
    typedef enum logic [3:0] {
        add   = 4'd0,
        sll   = 4'd1,
        slt   = 4'd2,
        passB = 4'd3,
        xorOp = 4'd4,
        srl   = 4'd5,
        orOp  = 4'd6,
        andOp = 4'd7,
        mul   = 4'd8,
        div   = 4'd12,
        rem   = 4'd14
    } aluOpT;

    typedef enum logic {
        pc  = 1'b0,
        rs1 = 1'b1
    } srcAT;

    typedef enum logic [1:0] {
        imm  = 2'd0,
        rs2  = 2'd1,
        four = 2'd2
    } srcBT;

    typedef enum logic [3:0] {
        none,
        beq,
        bne,
        blt,
        bge,
        bltu,
        bgeu,
        jal,
        jalr
    } branchT;

    typedef struct packed {
        aluOpT op;
        logic  isUnsigned;  // also arithmetic shift select
        logic  isSub;
        srcAT  srcA;
        srcBT  srcB;
        logic  isTruncate;  // word op, keep low 32 bits
        logic  isSext;
    } aluCtrlT;

    typedef struct packed {
        aluCtrlT ctrl;
        branchT  branch;
        xlenT    pc;
        xlenT    rs1Data;
        xlenT    rs2Data;
        xlenT    imm;
    } issueT;

endpackage

`default_nettype wire

// ==== alu/adder.sv ====
`timescale 1ns/1ns
`default_nettype none

module adder (
    input  wire execPkg::xlenT a,
    input  wire execPkg::xlenT b,
    input  wire                subtract,
    output execPkg::xlenT      sum,
    output logic               carry,
    output logic               overflow,
    output logic               zero
);

    execPkg::xlenT bIn;

    // two's complement subtract via inverted b and carry in
    assign bIn = subtract ? ~b : b;

    assign {carry, sum} = {1'b0, a} + {1'b0, bIn} + {64'b0, subtract};

    // same input signs, different result sign
    assign overflow = (a[63] == bIn[63]) && (sum[63] != a[63]);

    assign zero = (sum == '0);

endmodule

`default_nettype wire

// ==== alu/barrelShifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module barrelShifter (
    input  wire execPkg::xlenT  din,
    input  wire execPkg::shamtT shamt,
    input  wire                 arithmetic,
    input  wire                 left,
    input  wire                 word,
    output execPkg::xlenT       dout
);

    execPkg::shamtT amount;
    execPkg::xlenT  source;
    execPkg::xlenT  stage [0:6];
    logic           fill;

    // word mode: 5-bit amount, upper half pre-filled so right shifts
    // pull bit 31 (or zero) into the low word
    always_comb begin
        if (word) begin
            amount = {1'b0, shamt[4:0]};
            source = {{32{arithmetic & din[31]}}, din[31:0]};
        end else begin
            amount = shamt;
            source = din;
        end
    end

    assign fill     = arithmetic & source[63];
    assign stage[0] = source;

    // one stage per amount bit
    for (genvar i = 0; i < 6; i++) begin : stageGen
        localparam int step = 1 << i;
        execPkg::xlenT moved;

        assign moved = left ? {stage[i][63-step:0], {step{1'b0}}}
                            : {{step{fill}}, stage[i][63:step]};
        assign stage[i+1] = amount[i] ? moved : stage[i];
    end

    assign dout = stage[6];

endmodule

`default_nettype wire

// ==== alu/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire execPkg::aluCtrlT ctrl,
    input  wire execPkg::xlenT    pc,
    input  wire execPkg::xlenT    rs1Data,
    input  wire execPkg::xlenT    rs2Data,
    input  wire execPkg::xlenT    imm,
    output execPkg::xlenT         aluResult,
    output logic                  less,
    output logic                  zero
);

    execPkg::xlenT opA;
    execPkg::xlenT opB;
    execPkg::xlenT sum;
    execPkg::xlenT shifted;
    execPkg::xlenT product;
    execPkg::xlenT dividend;
    execPkg::xlenT divisor;
    execPkg::xlenT quotient;
    execPkg::xlenT remainder;
    execPkg::xlenT rawResult;
    logic          subtract;
    logic          carry;
    logic          overflow;
    logic          divOverflow;

    assign opA = (ctrl.srcA == execPkg::rs1) ? rs1Data : pc;

    always_comb begin
        case (ctrl.srcB)
            execPkg::imm:  opB = imm;
            execPkg::rs2:  opB = rs2Data;
            execPkg::four: opB = 64'd4;
            default:       opB = '0;
        endcase
    end

    // slt always compares by subtraction
    assign subtract = ctrl.isSub || (ctrl.op == execPkg::slt);

    adder adderInst (
        .a       (opA),
        .b       (opB),
        .subtract(subtract),
        .sum     (sum),
        .carry   (carry),
        .overflow(overflow),
        .zero    (zero)
    );

    // signed: sign xor overflow, unsigned: borrow out
    assign less = ctrl.isUnsigned ? (subtract ^ carry) : (sum[63] ^ overflow);

    barrelShifter shifterInst (
        .din       (opA),
        .shamt     (opB[5:0]),
        .arithmetic(ctrl.isUnsigned),
        .left      (ctrl.op == execPkg::sll),
        .word      (ctrl.isTruncate),
        .dout      (shifted)
    );

    assign product = opA * opB;  // low half only

    // word forms divide extended 32-bit operands on the same divider
    always_comb begin
        if (!ctrl.isTruncate) begin
            dividend = opA;
            divisor  = opB;
        end else if (ctrl.isUnsigned) begin
            dividend = {32'b0, opA[31:0]};
            divisor  = {32'b0, opB[31:0]};
        end else begin
            dividend = {{32{opA[31]}}, opA[31:0]};
            divisor  = {{32{opB[31]}}, opB[31:0]};
        end
        divOverflow = !ctrl.isUnsigned && (dividend == {1'b1, 63'b0}) && (divisor == '1);
        if (divisor == '0) begin
            quotient  = '1;
            remainder = dividend;
        end else if (divOverflow) begin
            quotient  = dividend;
            remainder = '0;
        end else if (ctrl.isUnsigned) begin
            quotient  = dividend / divisor;
            remainder = dividend % divisor;
        end else begin
            quotient  = $signed(dividend) / $signed(divisor);
            remainder = $signed(dividend) % $signed(divisor);
        end
    end

    always_comb begin
        case (ctrl.op)
            execPkg::add:   rawResult = sum;
            execPkg::sll:   rawResult = shifted;
            execPkg::srl:   rawResult = shifted;
            execPkg::slt:   rawResult = {63'b0, less};
            execPkg::passB: rawResult = opB;
            execPkg::xorOp: rawResult = opA ^ opB;
            execPkg::orOp:  rawResult = opA | opB;
            execPkg::andOp: rawResult = opA & opB;
            execPkg::mul:   rawResult = product;
            execPkg::div:   rawResult = quotient;
            execPkg::rem:   rawResult = remainder;
            default:        rawResult = '0;
        endcase
    end

    assign aluResult = !ctrl.isTruncate ? rawResult :
                       ctrl.isSext      ? {{32{rawResult[31]}}, rawResult[31:0]} :
                                          {32'b0, rawResult[31:0]};

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  wire execPkg::instrT instruction,
    input  wire execPkg::xlenT  pc,
    input  wire execPkg::xlenT  rs1Data,
    input  wire execPkg::xlenT  rs2Data,
    output execPkg::issueT      decoded
);

    localparam logic [6:0] opReg      = 7'b0110011;
    localparam logic [6:0] opImm      = 7'b0010011;
    localparam logic [6:0] opReg32    = 7'b0111011;
    localparam logic [6:0] opImm32    = 7'b0011011;
    localparam logic [6:0] opLui      = 7'b0110111;
    localparam logic [6:0] opAuipc    = 7'b0010111;
    localparam logic [6:0] opJal      = 7'b1101111;
    localparam logic [6:0] opJalr     = 7'b1100111;
    localparam logic [6:0] opBranch   = 7'b1100011;
    localparam logic [6:0] mulDivFunc = 7'b0000001;

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic           isWord;
    logic           illegal;
    execPkg::aluOpT baseOp;
    execPkg::xlenT  iImm;
    execPkg::xlenT  uImm;
    execPkg::xlenT  jImm;
    execPkg::xlenT  bImm;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign isWord = (opcode == opReg32) || (opcode == opImm32);

    // sltu shares slt, the rest map straight from funct3
    assign baseOp = (funct3 == 3'b011) ? execPkg::slt : execPkg::aluOpT'({1'b0, funct3});

    assign iImm = {{52{instruction[31]}}, instruction[31:20]};
    assign uImm = {{32{instruction[31]}}, instruction[31:12], 12'b0};
    assign jImm = {{44{instruction[31]}}, instruction[19:12], instruction[20],
                   instruction[30:21], 1'b0};
    assign bImm = {{52{instruction[31]}}, instruction[7], instruction[30:25],
                   instruction[11:8], 1'b0};

    always_comb begin
        decoded         = '0;
        decoded.ctrl.op = execPkg::passB;
        decoded.pc      = pc;
        decoded.rs1Data = rs1Data;
        decoded.rs2Data = rs2Data;
        illegal         = 1'b0;
        case (opcode)
            opReg, opReg32: begin
                decoded.ctrl.srcA = execPkg::rs1;
                decoded.ctrl.srcB = execPkg::rs2;
                if (funct7 == mulDivFunc) begin
                    decoded.ctrl.isUnsigned = funct3[0];
                    case (funct3[2:1])
                        2'b10:   decoded.ctrl.op = execPkg::div;
                        2'b11:   decoded.ctrl.op = execPkg::rem;
                        default: begin
                            decoded.ctrl.op = execPkg::mul;
                            illegal = (funct3 != 3'b000);  // no high-half multiply
                        end
                    endcase
                end else begin
                    decoded.ctrl.op         = baseOp;
                    decoded.ctrl.isSub      = funct7[5] && (funct3 == 3'b000);
                    decoded.ctrl.isUnsigned = (funct3 == 3'b011) ||
                                              (funct7[5] && (funct3 == 3'b101));
                    illegal = (funct7[6] || (funct7[4:0] != 5'b0)) ||
                              (isWord && !(funct3 inside {3'b000, 3'b001, 3'b101}));
                end
            end
            opImm, opImm32: begin
                decoded.ctrl.srcA       = execPkg::rs1;
                decoded.ctrl.op         = baseOp;
                decoded.ctrl.isUnsigned = (funct3 == 3'b011) ||
                                          (instruction[30] && (funct3 == 3'b101));
                decoded.imm = iImm;
                illegal = isWord && !(funct3 inside {3'b000, 3'b001, 3'b101});
            end
            opLui: begin
                decoded.imm = uImm;  // passB of the immediate
            end
            opAuipc: begin
                decoded.ctrl.op = execPkg::add;
                decoded.imm     = uImm;
            end
            opJal, opJalr: begin
                // link value pc+4, target formed in the resolver
                decoded.ctrl.op   = execPkg::add;
                decoded.ctrl.srcB = execPkg::four;
                decoded.branch    = (opcode == opJal) ? execPkg::jal : execPkg::jalr;
                decoded.imm       = (opcode == opJal) ? jImm : iImm;
                illegal = (opcode == opJalr) && (funct3 != 3'b000);
            end
            opBranch: begin
                decoded.ctrl.op         = execPkg::add;
                decoded.ctrl.isSub      = 1'b1;
                decoded.ctrl.srcA       = execPkg::rs1;
                decoded.ctrl.srcB       = execPkg::rs2;
                decoded.ctrl.isUnsigned = funct3[1];  // bltu, bgeu
                decoded.imm             = bImm;
                case (funct3)
                    3'b000:  decoded.branch = execPkg::beq;
                    3'b001:  decoded.branch = execPkg::bne;
                    3'b100:  decoded.branch = execPkg::blt;
                    3'b101:  decoded.branch = execPkg::bge;
                    3'b110:  decoded.branch = execPkg::bltu;
                    3'b111:  decoded.branch = execPkg::bgeu;
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        decoded.ctrl.isTruncate = isWord;
        decoded.ctrl.isSext     = isWord;  // RV64 W results always sign-extend
        if (illegal) begin
            // passB of a zero immediate gives a zero result
            decoded.ctrl    = '0;
            decoded.ctrl.op = execPkg::passB;
            decoded.branch  = execPkg::none;
            decoded.imm     = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issueRegister.sv ====
`timescale 1ns/1ns
`default_nettype none

module issueRegister (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 issueValid,
    input  wire execPkg::issueT decoded,
    output execPkg::issueT      held,
    output logic                valid
);

    // valid follows the strobe every cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= issueValid;
        end
    end

    // operation is held until the next strobe
    always_ff @(posedge clock) begin
        if (issueValid) begin
            held <= decoded;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branchResolver.sv ====
`timescale 1ns/1ns
`default_nettype none

module branchResolver (
    input  wire execPkg::issueT held,
    input  wire                 valid,
    input  wire                 less,
    input  wire                 zero,
    output logic                branchTaken,
    output execPkg::xlenT       branchTarget
);

    execPkg::xlenT base;
    execPkg::xlenT target;
    logic          taken;

    // jalr is relative to rs1, everything else to pc
    assign base   = (held.branch == execPkg::jalr) ? held.rs1Data : held.pc;
    assign target = base + held.imm;

    assign branchTarget = (held.branch == execPkg::jalr) ? {target[63:1], 1'b0} : target;

    always_comb begin
        case (held.branch)
            execPkg::beq:  taken = zero;
            execPkg::bne:  taken = !zero;
            execPkg::blt:  taken = less;   // signed less from alu
            execPkg::bge:  taken = !less;
            execPkg::bltu: taken = less;   // unsigned less from alu
            execPkg::bgeu: taken = !less;
            execPkg::jal:  taken = 1'b1;
            execPkg::jalr: taken = 1'b1;
            default:       taken = 1'b0;
        endcase
    end

    assign branchTaken = valid && taken;

endmodule

`default_nettype wire

// ==== verilog/executeTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeTop (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 issueValid,
    input  wire execPkg::instrT instruction,
    input  wire execPkg::xlenT  pc,
    input  wire execPkg::xlenT  rs1Data,
    input  wire execPkg::xlenT  rs2Data,
    output logic                resultValid,
    output execPkg::xlenT       result,
    output logic                branchTaken,
    output execPkg::xlenT       branchTarget
);

    execPkg::issueT decoded;
    execPkg::issueT held;
    logic           less;
    logic           zero;

    instrDecoder decoderInst (
        .instruction(instruction),
        .pc         (pc),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .decoded    (decoded)
    );

    // single pipeline register, everything after it is combinational
    issueRegister issueInst (
        .clock     (clock),
        .reset     (reset),
        .issueValid(issueValid),
        .decoded   (decoded),
        .held      (held),
        .valid     (resultValid)
    );

    alu aluInst (
        .ctrl     (held.ctrl),
        .pc       (held.pc),
        .rs1Data  (held.rs1Data),
        .rs2Data  (held.rs2Data),
        .imm      (held.imm),
        .aluResult(result),
        .less     (less),
        .zero     (zero)
    );

    branchResolver resolverInst (
        .held        (held),
        .valid       (resultValid),
        .less        (less),
        .zero        (zero),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

endmodule

`default_nettype wire

// ==== testbench/executeTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeTb;

    localparam logic [6:0] opReg    = 7'h33;
    localparam logic [6:0] opImm    = 7'h13;
    localparam logic [6:0] opReg32  = 7'h3b;
    localparam logic [6:0] opImm32  = 7'h1b;
    localparam logic [6:0] opLui    = 7'h37;
    localparam logic [6:0] opAuipc  = 7'h17;
    localparam logic [6:0] opJal    = 7'h6f;
    localparam logic [6:0] opJalr   = 7'h67;
    localparam logic [6:0] opBranch = 7'h63;

    // one cycle per strobe, plus reset, idle gaps and margin
    localparam int opCount    = 143;
    localparam int cycleLimit = opCount + 5 + 50;

    logic                clock = 1'b0;
    logic                reset;
    logic                issueValid;
    execPkg::instrT      instruction;
    execPkg::xlenT       pc;
    execPkg::xlenT       rs1Data;
    execPkg::xlenT       rs2Data;
    logic                resultValid;
    execPkg::xlenT       result;
    logic                branchTaken;
    execPkg::xlenT       branchTarget;

    int seed       = 49;
    int cycles     = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testCount  = 0;

    executeTop executeTop_inst (
        .clock       (clock),
        .reset       (reset),
        .issueValid  (issueValid),
        .instruction (instruction),
        .pc          (pc),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .resultValid (resultValid),
        .result      (result),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic execPkg::xlenT randWord();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic execPkg::xlenT sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // instruction encoders, rd = x3, rs1 = x1, rs2 = x2
    function automatic execPkg::instrT rType(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [6:0] op);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic execPkg::instrT iType(input logic [11:0] imm, input logic [2:0] f3,
                                             input logic [6:0] op);
        return {imm, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic execPkg::instrT bType(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic execPkg::instrT jType(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd3, opJal};
    endfunction

    // RISC-V divide rules, 64-bit
    function automatic execPkg::xlenT refDiv(input execPkg::xlenT a, input execPkg::xlenT b,
                                             input bit signedOp, input bit wantRem);
        if (b == '0)
            return wantRem ? a : '1;
        if (signedOp && a == 64'h8000_0000_0000_0000 && b == '1)
            return wantRem ? '0 : a;
        if (signedOp && wantRem)
            return $signed(a) % $signed(b);
        if (signedOp)
            return $signed(a) / $signed(b);
        return wantRem ? a % b : a / b;
    endfunction

    // same rules on 32-bit operands
    function automatic logic [31:0] refDiv32(input logic [31:0] a, input logic [31:0] b,
                                             input bit signedOp, input bit wantRem);
        if (b == '0)
            return wantRem ? a : '1;
        if (signedOp && a == 32'h8000_0000 && b == '1)
            return wantRem ? '0 : a;
        if (signedOp && wantRem)
            return $signed(a) % $signed(b);
        if (signedOp)
            return $signed(a) / $signed(b);
        return wantRem ? a % b : a / b;
    endfunction

    function automatic logic expectTaken(input logic [2:0] f3, input execPkg::xlenT a,
                                         input execPkg::xlenT b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return !($signed(a) < $signed(b));
            3'd6:    return a < b;
            default: return !(a < b);
        endcase
    endfunction

    task automatic compareWord(input string name, input execPkg::xlenT got,
                               input execPkg::xlenT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compareValid(input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t: resultValid got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        $display("%-10s %s (%0d errors)", name,
                 (errorCount == startErrors) ? "ok" : "FAIL", errorCount - startErrors);
    endtask

    // called on a falling edge, returns on the next one with the result visible
    task automatic strobe(input execPkg::instrT instr, input execPkg::xlenT pcV,
                          input execPkg::xlenT a, input execPkg::xlenT b);
        issueValid  = 1'b1;
        instruction = instr;
        pc          = pcV;
        rs1Data     = a;
        rs2Data     = b;
        @(negedge clock);
        issueValid = 1'b0;
    endtask

    task automatic checkAlu(input string name, input execPkg::instrT instr,
                            input execPkg::xlenT pcV, input execPkg::xlenT a,
                            input execPkg::xlenT b, input execPkg::xlenT exp);
        strobe(instr, pcV, a, b);
        compareValid(resultValid, 1'b1);
        compareWord({name, " result"}, result, exp);
        compareBit({name, " branchTaken"}, branchTaken, 1'b0);
    endtask

    task automatic checkBranch(input string name, input execPkg::instrT instr,
                               input execPkg::xlenT pcV, input execPkg::xlenT a,
                               input execPkg::xlenT b, input logic expTaken,
                               input execPkg::xlenT expTarget, input bit isJump);
        strobe(instr, pcV, a, b);
        compareValid(resultValid, 1'b1);
        compareBit({name, " branchTaken"}, branchTaken, expTaken);
        compareWord({name, " branchTarget"}, branchTarget, expTarget);
        if (isJump)
            compareWord({name, " link result"}, result, pcV + 64'd4);
    endtask

    task automatic testPipeline();
        int            startErrors;
        execPkg::xlenT a;
        execPkg::xlenT b;
        startErrors = errorCount;
        compareValid(resultValid, 1'b0);
        compareBit("branchTaken after reset", branchTaken, 1'b0);
        a = randWord();
        b = randWord();
        checkAlu("add", rType(7'h00, 3'd0, opReg), '0, a, b, a + b);
        @(negedge clock);  // idle cycle, strobe must not repeat
        compareValid(resultValid, 1'b0);
        checkAlu("add b2b", rType(7'h00, 3'd0, opReg), '0, a, b, a + b);
        checkAlu("sub b2b", rType(7'h20, 3'd0, opReg), '0, a, b, a - b);
        @(negedge clock);
        compareValid(resultValid, 1'b0);
        reportTest("pipeline", startErrors);
    endtask

    task automatic testArith();
        int            startErrors;
        execPkg::xlenT a;
        execPkg::xlenT b;
        execPkg::xlenT pcV;
        execPkg::xlenT r;
        execPkg::xlenT uImm;
        startErrors = errorCount;
        a    = randWord();
        b    = randWord();
        pcV  = randWord();
        r    = randWord();
        uImm = {{32{r[31]}}, r[31:12], 12'b0};
        checkAlu("add", rType(7'h00, 3'd0, opReg), pcV, a, b, a + b);
        checkAlu("sub", rType(7'h20, 3'd0, opReg), pcV, a, b, a - b);
        checkAlu("and", rType(7'h00, 3'd7, opReg), pcV, a, b, a & b);
        checkAlu("or", rType(7'h00, 3'd6, opReg), pcV, a, b, a | b);
        checkAlu("xor", rType(7'h00, 3'd4, opReg), pcV, a, b, a ^ b);
        checkAlu("addi", iType(r[43:32], 3'd0, opImm), pcV, a, b,
                 a + {{52{r[43]}}, r[43:32]});
        checkAlu("lui", {r[31:12], 5'd3, opLui}, pcV, a, b, uImm);
        checkAlu("auipc", {r[31:12], 5'd3, opAuipc}, pcV, a, b, pcV + uImm);
        checkAlu("addw", rType(7'h00, 3'd0, opReg32), pcV, a, b, sext32(a[31:0] + b[31:0]));
        checkAlu("subw", rType(7'h20, 3'd0, opReg32), pcV, a, b, sext32(a[31:0] - b[31:0]));
        reportTest("arith", startErrors);
    endtask

    task automatic testShifts();
        int             startErrors;
        execPkg::shamtT amounts [4];
        execPkg::shamtT s;
        logic [4:0]     w;
        execPkg::xlenT  a;
        execPkg::xlenT  b;
        startErrors = errorCount;
        amounts = '{6'd0, 6'd31, 6'd32, 6'd63};
        for (int i = 0; i < 4; i++) begin
            s = amounts[i];
            w = s[4:0];  // word forms see only five bits
            a = randWord() | 64'h8000_0000_8000_0000;  // negative in both widths
            b = randWord();
            b[5:0] = s;
            checkAlu("sll", rType(7'h00, 3'd1, opReg), '0, a, b, a << s);
            checkAlu("srl", rType(7'h00, 3'd5, opReg), '0, a, b, a >> s);
            checkAlu("sra", rType(7'h20, 3'd5, opReg), '0, a, b, $signed(a) >>> s);
            checkAlu("slli", iType({6'b000000, s}, 3'd1, opImm), '0, a, b, a << s);
            checkAlu("srli", iType({6'b000000, s}, 3'd5, opImm), '0, a, b, a >> s);
            checkAlu("srai", iType({6'b010000, s}, 3'd5, opImm), '0, a, b, $signed(a) >>> s);
            checkAlu("sllw", rType(7'h00, 3'd1, opReg32), '0, a, b, sext32(a[31:0] << w));
            checkAlu("srlw", rType(7'h00, 3'd5, opReg32), '0, a, b, sext32(a[31:0] >> w));
            checkAlu("sraw", rType(7'h20, 3'd5, opReg32), '0, a, b,
                     sext32($signed(a[31:0]) >>> w));
            checkAlu("slliw", iType({7'h00, w}, 3'd1, opImm32), '0, a, b, sext32(a[31:0] << w));
            checkAlu("srliw", iType({7'h00, w}, 3'd5, opImm32), '0, a, b, sext32(a[31:0] >> w));
            checkAlu("sraiw", iType({7'h20, w}, 3'd5, opImm32), '0, a, b,
                     sext32($signed(a[31:0]) >>> w));
        end
        reportTest("shifts", startErrors);
    endtask

    task automatic testCompare();
        int            startErrors;
        execPkg::xlenT as [3];
        execPkg::xlenT bs [3];
        execPkg::xlenT minusOne;
        startErrors = errorCount;
        minusOne = '1;
        // first two pairs make signed and unsigned answers disagree
        as = '{64'hffff_ffff_ffff_ffff, 64'd1, randWord()};
        bs = '{64'd1, 64'hffff_ffff_ffff_ffff, randWord()};
        for (int i = 0; i < 3; i++) begin
            checkAlu("slt", rType(7'h00, 3'd2, opReg), '0, as[i], bs[i],
                     {63'b0, $signed(as[i]) < $signed(bs[i])});
            checkAlu("sltu", rType(7'h00, 3'd3, opReg), '0, as[i], bs[i],
                     {63'b0, as[i] < bs[i]});
            checkAlu("slti", iType(12'hfff, 3'd2, opImm), '0, as[i], bs[i],
                     {63'b0, $signed(as[i]) < $signed(minusOne)});
            checkAlu("sltiu", iType(12'hfff, 3'd3, opImm), '0, as[i], bs[i],
                     {63'b0, as[i] < minusOne});
        end
        reportTest("compare", startErrors);
    endtask

    task automatic testMulDiv();
        int            startErrors;
        execPkg::xlenT as [5];
        execPkg::xlenT bs [5];
        execPkg::xlenT a;
        execPkg::xlenT b;
        startErrors = errorCount;
        as = '{randWord(), randWord(), 64'h8000_0000_0000_0000, 64'hffff_ffff_8000_0000,
               64'hffff_ffff_ffff_fff9};
        bs = '{randWord(), 64'd0, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 64'd2};
        for (int i = 0; i < 5; i++) begin
            a = as[i];
            b = bs[i];
            checkAlu("mul", rType(7'h01, 3'd0, opReg), '0, a, b, a * b);
            checkAlu("div", rType(7'h01, 3'd4, opReg), '0, a, b, refDiv(a, b, 1, 0));
            checkAlu("divu", rType(7'h01, 3'd5, opReg), '0, a, b, refDiv(a, b, 0, 0));
            checkAlu("rem", rType(7'h01, 3'd6, opReg), '0, a, b, refDiv(a, b, 1, 1));
            checkAlu("remu", rType(7'h01, 3'd7, opReg), '0, a, b, refDiv(a, b, 0, 1));
            checkAlu("mulw", rType(7'h01, 3'd0, opReg32), '0, a, b, sext32(a[31:0] * b[31:0]));
            checkAlu("divw", rType(7'h01, 3'd4, opReg32), '0, a, b,
                     sext32(refDiv32(a[31:0], b[31:0], 1, 0)));
            checkAlu("divuw", rType(7'h01, 3'd5, opReg32), '0, a, b,
                     sext32(refDiv32(a[31:0], b[31:0], 0, 0)));
            checkAlu("remw", rType(7'h01, 3'd6, opReg32), '0, a, b,
                     sext32(refDiv32(a[31:0], b[31:0], 1, 1)));
            checkAlu("remuw", rType(7'h01, 3'd7, opReg32), '0, a, b,
                     sext32(refDiv32(a[31:0], b[31:0], 0, 1)));
        end
        reportTest("muldiv", startErrors);
    endtask

    task automatic testBranches();
        int            startErrors;
        string         kinds [6];
        logic [2:0]    funct3s [6];
        execPkg::xlenT as [3];
        execPkg::xlenT bs [3];
        execPkg::xlenT pcV;
        execPkg::xlenT a;
        logic [12:0]   bOff;
        logic [20:0]   jOff;
        logic [11:0]   jrOff;
        startErrors = errorCount;
        kinds   = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
        funct3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        pcV     = randWord() & ~64'h3;
        bOff    = 13'h1ff8;   // backward by 8
        jOff    = 21'h1ff804;
        jrOff   = 12'h801;    // odd, so bit 0 clearing shows
        a       = randWord();
        // equal, then signed and unsigned order disagreeing both ways
        as = '{a, 64'hffff_ffff_ffff_ffff, 64'd1};
        bs = '{a, 64'd1, 64'hffff_ffff_ffff_ffff};
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 3; i++) begin
                checkBranch(kinds[k], bType(bOff, funct3s[k]), pcV, as[i], bs[i],
                            expectTaken(funct3s[k], as[i], bs[i]),
                            pcV + {{51{bOff[12]}}, bOff}, 0);
            end
        end
        checkBranch("jal", jType(jOff), pcV, a, '0, 1'b1, pcV + {{43{jOff[20]}}, jOff}, 1);
        // even base, so the odd sum needs its low bit cleared
        checkBranch("jalr", iType(jrOff, 3'd0, opJalr), pcV, {a[63:1], 1'b0}, '0, 1'b1,
                    ({a[63:1], 1'b0} + {{52{jrOff[11]}}, jrOff}) & ~64'h1, 1);
        reportTest("branches", startErrors);
    endtask

    initial begin
        reset       = 1'b1;
        // a jal strobed during reset must not leave valid or taken high
        issueValid  = 1'b1;
        instruction = jType(21'h0);
        pc          = '0;
        rs1Data     = '0;
        rs2Data     = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset      = 1'b0;
        issueValid = 1'b0;
        testPipeline();
        testArith();
        testShifts();
        testCompare();
        testMulDiv();
        testBranches();
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/execPkg.sv
alu/adder.sv
alu/barrelShifter.sv
alu/alu.sv
verilog/instrDecoder.sv
verilog/issueRegister.sv
verilog/branchResolver.sv
verilog/executeTop.sv
testbench/executeTb.sv
